/* verilog/zx_map_pkg.sv */
////////////////////////////////////////////////////////////
// shared types and constants of the zx memory mapper
// four 16 KB windows, two banks each, bank chosen by 7FFD bit 4
////////////////////////////////////////////////////////////
`default_nettype none

package zx_map_pkg;

	// kinds of sampled z80 bus cycles
	typedef enum logic [1:0]
	{
		MEM_RD   = 2'd0,
		M1_FETCH = 2'd1,
		IO_RD    = 2'd2,
		IO_WR    = 2'd3
	} bus_kind_e;

	// bit 7 rom flag, bits 5:0 page number, bit 6 only stored
	typedef logic [7:0] page_t;

	localparam int ROM_BIT = 7;
	localparam int PAGE_W  = 6;

	// window and bank counts
	localparam int NUM_WIN   = 4;
	localparam int NUM_PAGES = 2 * NUM_WIN;

	// 7FFD bit that picks the bank
	localparam int BANK_BIT_7FFD = 4;

	////////////////////////////////////////////////////////////
	// port and area decodes
	////////////////////////////////////////////////////////////

	// low address byte of the page write port
	localparam logic [7:0] PORT_PAGE_LO     = 8'hF7;
	// low address byte of the page readback port
	localparam logic [7:0] PORT_READBACK_LO = 8'hBE;
	// high address byte of the dos entry area
	localparam logic [7:0] DOS_AREA_HI      = 8'h3D;

	// reset pages per window, same for both banks
	// window 0 rom page 0, then ram pages 1 to 3
	localparam page_t [NUM_WIN-1:0] RESET_PAGE =
	{
		8'h03,
		8'h02,
		8'h01,
		8'h80
	};

endpackage

`default_nettype wire

/* verilog/zbus_if.sv */
////////////////////////////////////////////////////////////
// one registered bus command, driven only by the decoder
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface zbus_if;

	import zx_map_pkg::*;

	// command registered from one strobe
	logic        cmd_valid;
	bus_kind_e   cmd_kind;
	logic [15:0] cmd_addr;
	logic [7:0]  cmd_data;

	// 7FFD bit 4 as seen by this command
	logic        bank;

	// one cycle pulses for port hits
	logic        page_wr;
	logic        rb_rd;

	modport dec
	(
		output cmd_valid, cmd_kind, cmd_addr, cmd_data, bank, page_wr, rb_rd
	);

	modport pager
	(
		input page_wr, cmd_addr, cmd_data, bank
	);

	modport dos
	(
		input cmd_valid, cmd_kind, cmd_addr
	);

	modport map
	(
		input cmd_valid, cmd_kind, cmd_addr, bank, rb_rd
	);

endinterface

`default_nettype wire

/* verilog/zbus_decode.sv */
////////////////////////////////////////////////////////////
// one strobe per bus cycle, no back-pressure
// 7FFD write takes effect for the next strobe
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module zbus_decode
(
	input  wire                   fclk,
	input  wire                   arst_n,

	input  wire                   bus_stb,
	input  zx_map_pkg::bus_kind_e bus_kind,
	input  wire  [15:0]           addr,
	input  wire  [7:0]            wdata,

	zbus_if.dec                   bus
);

	import zx_map_pkg::*;

	logic hit_page_wr;
	logic hit_rb_rd;
	logic hit_7ffd;

	// only bit 4 of 7FFD matters here
	logic p7ffd_bank;

	////////////////////////////////////////////////////////////
	// port decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		hit_page_wr = bus_stb && (bus_kind == IO_WR) && (addr[7:0] == PORT_PAGE_LO);
		hit_rb_rd   = bus_stb && (bus_kind == IO_RD) && (addr[7:0] == PORT_READBACK_LO);
		// partial decode on a15 and a1 low
		hit_7ffd    = bus_stb && (bus_kind == IO_WR) && !addr[15] && !addr[1];
	end

	// 7FFD register
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			p7ffd_bank <= 1'b0;
		else if (hit_7ffd)
			p7ffd_bank <= wdata[BANK_BIT_7FFD];
	end

	////////////////////////////////////////////////////////////
	// command register
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bus.cmd_valid <= 1'b0;
			bus.page_wr   <= 1'b0;
			bus.rb_rd     <= 1'b0;
		end
		else
		begin
			bus.cmd_valid <= bus_stb;
			bus.page_wr   <= hit_page_wr;
			bus.rb_rd     <= hit_rb_rd;
		end
	end

	// payload keeps the bank from before this strobe's own write
	always_ff @(posedge fclk)
	begin
		if (bus_stb)
		begin
			bus.cmd_kind <= bus_kind;
			bus.cmd_addr <= addr;
			bus.cmd_data <= wdata;
			bus.bank     <= p7ffd_bank;
		end
	end

endmodule

`default_nettype wire

/* verilog/atm_pager.sv */
////////////////////////////////////////////////////////////
// page registers of one 16 KB window, two banks
// written by port F7 with a15:a14 equal to the window index
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module atm_pager
#(
	parameter int win_index = 0
)
(
	input  wire                fclk,
	input  wire                arst_n,

	zbus_if.pager              bus,

	output zx_map_pkg::page_t  bank0_page,
	output zx_map_pkg::page_t  bank1_page
);

	import zx_map_pkg::*;

	logic win_hit;

	// address picks the window, 7FFD picks the bank
	always_comb
	begin
		win_hit = bus.page_wr && (bus.cmd_addr[15:14] == win_index[1:0]);
	end

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bank0_page <= RESET_PAGE[win_index];
			bank1_page <= RESET_PAGE[win_index];
		end
		else if (win_hit)
		begin
			if (bus.bank)
				bank1_page <= bus.cmd_data;
			else
				bank0_page <= bus.cmd_data;
		end
	end

endmodule

`default_nettype wire

/* verilog/zdos.sv */
////////////////////////////////////////////////////////////
// dos flag, changed only by M1 fetches
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module zdos
(
	input  wire   fclk,
	input  wire   arst_n,

	zbus_if.dos   bus,

	input  wire   win0_rom,
	input  wire   cur_rom,

	output logic  dos
);

	import zx_map_pkg::*;

	logic is_m1;
	logic dos_on;
	logic dos_off;

	always_comb
	begin
		is_m1   = bus.cmd_valid && (bus.cmd_kind == M1_FETCH);
		// entry into 3Dxx while rom sits in window 0
		dos_on  = is_m1 && (bus.cmd_addr[15:8] == DOS_AREA_HI) && win0_rom;
		// any fetch from ram leaves dos
		dos_off = is_m1 && !cur_rom;
	end

	// set wins over clear
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			dos <= 1'b0;
		else if (dos_on)
			dos <= 1'b1;
		else if (dos_off)
			dos <= 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/page_map.sv */
////////////////////////////////////////////////////////////
// window translation and xxBE readback, one register stage
// page index is bank * 4 + window
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module page_map
(
	input  wire                                           fclk,
	input  wire                                           arst_n,

	zbus_if.map                                           bus,

	input  zx_map_pkg::page_t [zx_map_pkg::NUM_PAGES-1:0] pages,

	// selection for the dos controller
	output logic                                          win0_rom,
	output logic                                          cur_rom,

	output logic                                          xlat_valid,
	output logic                                          xlat_rom,
	output logic [zx_map_pkg::PAGE_W-1:0]                 xlat_page,

	output logic [7:0]                                    rdata,
	output logic                                          rdata_valid
);

	import zx_map_pkg::*;

	logic  is_mem;
	page_t cur_page;
	page_t win0_page;
	page_t rb_page;

	////////////////////////////////////////////////////////////
	// selection
	////////////////////////////////////////////////////////////

	always_comb
	begin
		is_mem    = bus.cmd_valid &&
		            ((bus.cmd_kind == MEM_RD) || (bus.cmd_kind == M1_FETCH));
		cur_page  = pages[{bus.bank, bus.cmd_addr[15:14]}];
		win0_page = pages[{bus.bank, 2'd0}];
		// readback takes the bank from a10 and the window from a9:a8
		rb_page   = pages[bus.cmd_addr[10:8]];

		win0_rom  = win0_page[ROM_BIT];
		cur_rom   = cur_page[ROM_BIT];
	end

	////////////////////////////////////////////////////////////
	// result registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			xlat_valid  <= 1'b0;
			rdata_valid <= 1'b0;
		end
		else
		begin
			xlat_valid  <= is_mem;
			rdata_valid <= bus.rb_rd;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (is_mem)
		begin
			xlat_rom  <= cur_page[ROM_BIT];
			xlat_page <= cur_page[PAGE_W-1:0];
		end
		// full byte including bit 6
		if (bus.rb_rd)
			rdata <= rb_page;
	end

endmodule

`default_nettype wire

/* verilog/zx_mapper_top.sv */
////////////////////////////////////////////////////////////
// z80 memory mapper, results two cycles after each strobe
// memory data and real bus pins are not handled
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module zx_mapper_top
(
	input  wire                              fclk,
	input  wire                              arst_n,

	// sampled bus cycle
	input  wire                              bus_stb,
	input  zx_map_pkg::bus_kind_e            bus_kind,
	input  wire  [15:0]                      addr,
	input  wire  [7:0]                       wdata,

	// xxBE readback
	output logic [7:0]                       rdata,
	output logic                             rdata_valid,

	// translation of memory cycles
	output logic                             xlat_valid,
	output logic                             xlat_rom,
	output logic [zx_map_pkg::PAGE_W-1:0]    xlat_page,

	output logic                             dos
);

	import zx_map_pkg::*;

	// bank 0 pages at 0..3, bank 1 pages at 4..7
	page_t [NUM_PAGES-1:0] pages;

	logic win0_rom;
	logic cur_rom;

	zbus_if bus_i ();

	zbus_decode u_decode
	(
		.fclk     (fclk),
		.arst_n   (arst_n),
		.bus_stb  (bus_stb),
		.bus_kind (bus_kind),
		.addr     (addr),
		.wdata    (wdata),
		.bus      (bus_i.dec)
	);

	////////////////////////////////////////////////////////////
	// window pagers
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_WIN; i++)
	begin : g_pager
		atm_pager #(.win_index(i)) u_pager
		(
			.fclk       (fclk),
			.arst_n     (arst_n),
			.bus        (bus_i.pager),
			.bank0_page (pages[i]),
			.bank1_page (pages[i + NUM_WIN])
		);
	end

	zdos u_zdos
	(
		.fclk     (fclk),
		.arst_n   (arst_n),
		.bus      (bus_i.dos),
		.win0_rom (win0_rom),
		.cur_rom  (cur_rom),
		.dos      (dos)
	);

	page_map u_map
	(
		.fclk        (fclk),
		.arst_n      (arst_n),
		.bus         (bus_i.map),
		.pages       (pages),
		.win0_rom    (win0_rom),
		.cur_rom     (cur_rom),
		.xlat_valid  (xlat_valid),
		.xlat_rom    (xlat_rom),
		.xlat_page   (xlat_page),
		.rdata       (rdata),
		.rdata_valid (rdata_valid)
	);

endmodule

`default_nettype wire

/* tb/tb_mapper_properties.sv */
////////////////////////////////////////////////////////////
// bound to zx_mapper_top, sees only its ports
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_mapper_properties
(
	input wire                   fclk,
	input wire                   arst_n,
	input wire                   bus_stb,
	input zx_map_pkg::bus_kind_e bus_kind,
	input wire [15:0]            addr,
	input wire                   xlat_valid,
	input wire                   rdata_valid
);

	import zx_map_pkg::*;

	logic mem_stb;
	logic rb_stb;

	// number of failed assertions
	int   fail_count;

	initial
	begin
		fail_count = 0;
	end

	always_comb
	begin
		mem_stb = bus_stb && ((bus_kind == MEM_RD) || (bus_kind == M1_FETCH));
		rb_stb  = bus_stb && (bus_kind == IO_RD) && (addr[7:0] == PORT_READBACK_LO);
	end

	valid_in_reset: assert property (@(posedge fclk)
		!arst_n |-> !xlat_valid && !rdata_valid)
		else
		begin
			$error("valid output high during reset");
			fail_count++;
		end

	one_valid: assert property (@(posedge fclk) disable iff (!arst_n)
		!(xlat_valid && rdata_valid))
		else
		begin
			$error("xlat_valid and rdata_valid high together");
			fail_count++;
		end

	// two cycles from strobe to result in both directions
	xlat_after_mem: assert property (@(posedge fclk) disable iff (!arst_n)
		mem_stb |-> ##2 xlat_valid)
		else
		begin
			$error("no xlat_valid two cycles after a memory strobe");
			fail_count++;
		end

	xlat_only_after_mem: assert property (@(posedge fclk) disable iff (!arst_n)
		xlat_valid |-> $past(mem_stb, 2))
		else
		begin
			$error("xlat_valid without a memory strobe two cycles before");
			fail_count++;
		end

	rdata_after_rb: assert property (@(posedge fclk) disable iff (!arst_n)
		rb_stb |-> ##2 rdata_valid)
		else
		begin
			$error("no rdata_valid two cycles after a readback strobe");
			fail_count++;
		end

	rdata_only_after_rb: assert property (@(posedge fclk) disable iff (!arst_n)
		rdata_valid |-> $past(rb_stb, 2))
		else
		begin
			$error("rdata_valid without a readback strobe two cycles before");
			fail_count++;
		end

endmodule

bind zx_mapper_top tb_mapper_properties u_props
(
	.fclk        (fclk),
	.arst_n      (arst_n),
	.bus_stb     (bus_stb),
	.bus_kind    (bus_kind),
	.addr        (addr),
	.xlat_valid  (xlat_valid),
	.rdata_valid (rdata_valid)
);

`default_nettype wire

/* tb/tb_mapper.sv */
////////////////////////////////////////////////////////////
// random bus cycles against a model of pages, 7FFD bank and dos
// every result is checked two cycles after its strobe
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_mapper;

	import zx_map_pkg::*;

	localparam int NUM_STROBES    = 2000;
	// reset, directed reads, 2000 strobes with at most one idle cycle each, margin
	localparam int TIMEOUT_CYCLES = 6000;

	logic        fclk;
	logic        arst_n;
	logic        bus_stb;
	bus_kind_e   bus_kind;
	logic [15:0] addr;
	logic [7:0]  wdata;
	logic [7:0]  rdata;
	logic        rdata_valid;
	logic        xlat_valid;
	logic        xlat_rom;
	logic [5:0]  xlat_page;
	logic        dos;

	integer      seed;
	int          errors;
	int          checks;
	int          cycles;
	int          prop_fails;

	// model state, page index is bank * 4 + window
	logic [7:0]  m_pages [0:7];
	logic        m_bank;
	logic        m_dos;
	// {xlat_valid, xlat_rom, xlat_page, rdata_valid, rdata, dos}
	logic [17:0] exp_q [$];

	zx_mapper_top u_dut
	(
		.fclk        (fclk),
		.arst_n      (arst_n),
		.bus_stb     (bus_stb),
		.bus_kind    (bus_kind),
		.addr        (addr),
		.wdata       (wdata),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.xlat_valid  (xlat_valid),
		.xlat_rom    (xlat_rom),
		.xlat_page   (xlat_page),
		.dos         (dos)
	);

	initial
	begin
		fclk = 1'b0;
		forever #20 fclk = ~fclk;
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge fclk);
			cycles++;
		end
		$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_oldest(input string test);
		logic [17:0] e;
		e = exp_q.pop_front();
		compare({test, " xlat_valid"}, e[17], xlat_valid);
		compare({test, " rdata_valid"}, e[9], rdata_valid);
		compare({test, " dos"}, e[0], dos);
		if (e[17])
		begin
			compare({test, " xlat_rom"}, e[16], xlat_rom);
			compare({test, " xlat_page"}, e[15:10], xlat_page);
		end
		if (e[9])
			compare({test, " rdata"}, e[8:1], rdata);
	endtask

	////////////////////////////////////////////////////////////
	// stimulus and model
	////////////////////////////////////////////////////////////

	// drive on the falling edge, model the cycle in program order
	task automatic step(input string test, input logic stb, input bus_kind_e kind,
		input logic [15:0] a, input logic [7:0] d);
		logic [7:0]  cur;
		logic [17:0] e;
		@(negedge fclk);
		if (exp_q.size() == 2)
			check_oldest(test);
		bus_stb  = stb;
		bus_kind = kind;
		addr     = a;
		wdata    = d;
		e   = '0;
		cur = m_pages[{m_bank, a[15:14]}];
		if (stb && (kind == MEM_RD || kind == M1_FETCH))
		begin
			e[17:10] = {1'b1, cur[7], cur[5:0]};
			if (kind == M1_FETCH && a[15:8] == 8'h3D && m_pages[{m_bank, 2'b00}][7])
				m_dos = 1'b1;
			else if (kind == M1_FETCH && !cur[7])
				m_dos = 1'b0;
		end
		if (stb && kind == IO_RD && a[7:0] == 8'hBE)
			e[9:1] = {1'b1, m_pages[a[10:8]]};
		if (stb && kind == IO_WR && a[7:0] == 8'hF7)
			m_pages[{m_bank, a[15:14]}] = d;
		// 7FFD partial decode takes effect from the next strobe on
		if (stb && kind == IO_WR && !a[15] && !a[1])
			m_bank = d[4];
		e[0] = m_dos;
		exp_q.push_back(e);
	endtask

	// weighted toward F7, BE, 7FFD and the 3Dxx area
	task automatic random_strobe();
		logic [31:0] r;
		logic [15:0] a;
		logic [7:0]  d;
		r = $random(seed);
		a = r[31:16];
		d = r[15:8];
		case (r[3:0])
			4'd0, 4'd1, 4'd2: step("page_write", 1'b1, IO_WR, {a[15:8], 8'hF7}, d);
			4'd3, 4'd4:       step("bank_write", 1'b1, IO_WR, a & 16'h7FFD, d);
			4'd5, 4'd6:       step("readback", 1'b1, IO_RD, {a[15:8], 8'hBE}, d);
			4'd7, 4'd8:       step("dos_entry", 1'b1, M1_FETCH, {8'h3D, a[7:0]}, d);
			4'd9, 4'd10:      step("fetch", 1'b1, M1_FETCH, a, d);
			4'd14:            step("io_read", 1'b1, IO_RD, a, d);
			4'd15:            step("io_write", 1'b1, IO_WR, a, d);
			default:          step("mem_read", 1'b1, MEM_RD, a, d);
		endcase
		if (r[4])
			step("gap", 1'b0, MEM_RD, a, d);
	endtask

	initial
	begin
		seed     = 32'h4a2;
		errors   = 0;
		checks   = 0;
		arst_n   = 1'b0;
		bus_stb  = 1'b0;
		bus_kind = MEM_RD;
		addr     = '0;
		wdata    = '0;
		m_bank   = 1'b0;
		m_dos    = 1'b0;
		// window 0 rom page 0, then ram pages 1 to 3, both banks
		for (int i = 0; i < 8; i++)
			m_pages[i] = (i % 4 == 0) ? 8'h80 : 8'(i % 4);
		repeat (10) @(negedge fclk);
		arst_n = 1'b1;
		compare("reset dos", 8'h00, dos);
		// all four windows back to back
		for (int w = 0; w < 4; w++)
			step("reset_read", 1'b1, MEM_RD, 16'(w) << 14, 8'h00);
		for (int n = 0; n < NUM_STROBES; n++)
			random_strobe();
		repeat (2) step("drain", 1'b0, MEM_RD, 16'h0000, 8'h00);
		prop_fails = u_dut.u_props.fail_count;
		$display("%0d checks, %0d errors, %0d assertion failures",
			checks, errors, prop_fails);
		if (errors == 0 && prop_fails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
verilog/zx_map_pkg.sv
verilog/zbus_if.sv
verilog/zbus_decode.sv
verilog/atm_pager.sv
verilog/zdos.sv
verilog/page_map.sv
verilog/zx_mapper_top.sv
tb/tb_mapper_properties.sv
tb/tb_mapper.sv
